// File: dbg_bridge_config.svh
////////////////////////////////////////////////////////////
// Build-time settings of the debug bus access port
// RAM size and wait states apply to the scratch RAM only
// Only the little-endian lane order (value 1) is verified
////////////////////////////////////////////////////////////

`ifndef DBG_BRIDGE_CONFIG_SVH
`define DBG_BRIDGE_CONFIG_SVH

// Number of 32-bit words in the scratch RAM
`define DBG_RAM_WORDS 64

// Extra bus cycles before the RAM answers, 0 to 7
`define DBG_RAM_WAIT 2

// 1: lowest-addressed byte sits on bus bits 7:0
// 0: lane decode is mirrored for a big-endian bus
`define DBG_BUS_LITTLE_ENDIAN 1

`endif

// File: dbg_bridge_pkg.sv
////////////////////////////////////////////////////////////
// Shared types of the debug bus bridge
// Size codes match the debug unit's word_size field
////////////////////////////////////////////////////////////

`default_nettype none

package dbg_bridge_pkg;

  // Bus-side transfer FSM, one bit is enough
  typedef enum logic {
    BUS_IDLE     = 1'b0,
    BUS_TRANSFER = 1'b1
  } bus_state_e;

  // Access size as number of bytes
  // Codes outside this set are handled as a word
  typedef enum logic [2:0] {
    SIZE_BYTE = 3'd1,
    SIZE_HALF = 3'd2,
    SIZE_WORD = 3'd4
  } access_size_e;

endpackage

`default_nettype wire

// File: dbg_lane_steer.sv
////////////////////////////////////////////////////////////
// Byte-enable decode and data-lane steering, no registers
// Short write data arrives in the upper bits of the word
// Read data leaves right-aligned, upper bits undefined
////////////////////////////////////////////////////////////

`default_nettype none

`include "dbg_bridge_config.svh"

module dbg_lane_steer import dbg_bridge_pkg::*; (
  input  logic [1:0]   addr_low_i,
  input  access_size_e word_size_i,
  input  logic [31:0]  wr_data_i,
  input  logic [3:0]   sel_i,
  input  logic [31:0]  rd_bus_i,
  output logic [3:0]   sel_o,
  output logic [31:0]  wr_bus_o,
  output logic [31:0]  rd_data_o
);

  localparam bit LITTLE_END = (`DBG_BUS_LITTLE_ENDIAN != 0);

  // Lane enables in little-endian order
  logic [3:0] le_sel;
  // Right shift that brings the lowest enabled lane to bit 0
  logic [4:0] rd_shift;

  // Size and low address bits to lane enables
  always_comb begin
    case (word_size_i)
      SIZE_BYTE: le_sel = 4'b0001 << addr_low_i;
      SIZE_HALF: le_sel = addr_low_i[1] ? 4'b1100 : 4'b0011;
      SIZE_WORD: le_sel = 4'b1111;
      default:   le_sel = 4'b1111;
    endcase
  end

  // Big-endian bus just mirrors the lane order
  assign sel_o = LITTLE_END ? le_sel : {le_sel[0], le_sel[1], le_sel[2], le_sel[3]};

  // Short data is copied into every lane of its size,
  // sel then picks the lanes that really get written
  always_comb begin
    case (word_size_i)
      SIZE_BYTE: wr_bus_o = {4{wr_data_i[31:24]}};
      SIZE_HALF: wr_bus_o = {2{wr_data_i[31:16]}};
      default:   wr_bus_o = wr_data_i;
    endcase
  end

  // Lowest enabled lane of the latched sel sets the shift
  always_comb begin
    if (sel_i[0]) begin
      rd_shift = 5'd0;
    end else if (sel_i[1]) begin
      rd_shift = 5'd8;
    end else if (sel_i[2]) begin
      rd_shift = 5'd16;
    end else if (sel_i[3]) begin
      rd_shift = 5'd24;
    end else begin
      rd_shift = 5'd0;
    end
  end

  assign rd_data_o = rd_bus_i >> rd_shift;

endmodule

`default_nettype wire

// File: dbg_toggle_sync.sv
////////////////////////////////////////////////////////////
// Toggle crossing into the clk_i domain
// Input must hold each level for at least three clk_i edges
////////////////////////////////////////////////////////////

`default_nettype none

module dbg_toggle_sync (
  input  logic clk_i,
  input  logic rst_i,
  input  logic toggle_i,
  output logic pulse_o
);

  // Two metastability stages, then the previous value
  logic sync_q1;
  logic sync_q2;
  logic sync_q3;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      sync_q1 <= 1'b0;
      sync_q2 <= 1'b0;
      sync_q3 <= 1'b0;
    end else begin
      sync_q1 <= toggle_i;
      sync_q2 <= sync_q1;
      sync_q3 <= sync_q2;
    end
  end

  // One-cycle pulse on each change of level
  assign pulse_o = sync_q2 ^ sync_q3;

endmodule

`default_nettype wire

// File: dbg_bus_bridge.sv
////////////////////////////////////////////////////////////
// Debug to bus bridge, single transfers only
// One request in flight; strobe_i is ignored while rdy_o low
// data_o and err_o are valid once rdy_o has risen
////////////////////////////////////////////////////////////

`default_nettype none

module dbg_bus_bridge import dbg_bridge_pkg::*; (
  // Debug side, tck_i domain
  input  logic         tck_i,
  input  logic         rst_i,
  input  logic         strobe_i,
  input  logic         rd_wrn_i,
  input  access_size_e word_size_i,
  input  logic [31:0]  addr_i,
  input  logic [31:0]  data_i,
  output logic         rdy_o,
  output logic         err_o,
  output logic [31:0]  data_o,
  // Bus side, apb4_clk_i domain
  input  logic         apb4_clk_i,
  output logic [31:0]  apb4_adr_o,
  output logic [31:0]  apb4_dat_o,
  input  logic [31:0]  apb4_dat_i,
  output logic [3:0]   apb4_sel_o,
  output logic         apb4_we_o,
  output logic         apb4_cyc_o,
  output logic         apb4_stb_o,
  input  logic         apb4_ack_i,
  input  logic         apb4_err_i
);

  // Steering results
  logic [3:0]  dec_sel;
  logic [31:0] steered_wr;
  logic [31:0] aligned_rd;

  // Request held for the bus side
  logic [31:0] addr_q;
  logic [31:0] wdata_q;
  logic [3:0]  sel_q;
  logic        we_q;

  // Crossing toggles and their pulses
  logic start_tgl;
  logic start_pulse;
  logic ready_tgl;
  logic ready_pulse;

  logic accept;

  // Bus FSM
  bus_state_e state_q;
  bus_state_e state_d;
  logic       bus_active;
  logic       bus_answer;
  logic       bus_done;

  // Result returned to the debug side
  logic        err_q;
  logic [31:0] rdata_q;

  dbg_lane_steer u_steer (
    .addr_low_i  (addr_i[1:0]),
    .word_size_i (word_size_i),
    .wr_data_i   (data_i),
    .sel_i       (sel_q),
    .rd_bus_i    (apb4_dat_i),
    .sel_o       (dec_sel),
    .wr_bus_o    (steered_wr),
    .rd_data_o   (aligned_rd)
  );

  ////////////////////////////////////////////////////////////
  // TCK domain
  ////////////////////////////////////////////////////////////

  assign accept = strobe_i && rdy_o;

  // Address, lanes and write data only change on acceptance,
  // so they are stable while the bus side uses them
  always_ff @(posedge tck_i) begin
    if (accept) begin
      addr_q  <= addr_i;
      sel_q   <= dec_sel;
      wdata_q <= steered_wr;
    end
  end

  // Start toggle and ready flag
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      start_tgl <= 1'b0;
      we_q      <= 1'b0;
      rdy_o     <= 1'b1;
    end else if (accept) begin
      start_tgl <= ~start_tgl;
      we_q      <= ~rd_wrn_i;
      rdy_o     <= 1'b0;
    end else if (ready_pulse) begin
      rdy_o     <= 1'b1;
    end
  end

  // Start request into the bus domain
  dbg_toggle_sync u_start_sync (
    .clk_i    (apb4_clk_i),
    .rst_i    (rst_i),
    .toggle_i (start_tgl),
    .pulse_o  (start_pulse)
  );

  // Completion back into the tck domain
  dbg_toggle_sync u_ready_sync (
    .clk_i    (tck_i),
    .rst_i    (rst_i),
    .toggle_i (ready_tgl),
    .pulse_o  (ready_pulse)
  );

  ////////////////////////////////////////////////////////////
  // Bus clock domain
  ////////////////////////////////////////////////////////////

  assign bus_answer = apb4_ack_i || apb4_err_i;

  always_ff @(posedge apb4_clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= BUS_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // cyc/stb rise with the start pulse, fall after the answer
  // An answer in the start cycle skips BUS_TRANSFER
  always_comb begin
    state_d    = state_q;
    bus_active = 1'b0;
    bus_done   = 1'b0;
    case (state_q)
      BUS_IDLE: begin
        if (start_pulse) begin
          bus_active = 1'b1;
          if (bus_answer) begin
            bus_done = 1'b1;
          end else begin
            state_d = BUS_TRANSFER;
          end
        end
      end
      BUS_TRANSFER: begin
        bus_active = 1'b1;
        if (bus_answer) begin
          bus_done = 1'b1;
          state_d  = BUS_IDLE;
        end
      end
      default: state_d = BUS_IDLE;
    endcase
  end

  // Error flag and ready toggle, once per transfer
  always_ff @(posedge apb4_clk_i or posedge rst_i) begin
    if (rst_i) begin
      ready_tgl <= 1'b0;
      err_q     <= 1'b0;
    end else if (bus_done) begin
      ready_tgl <= ~ready_tgl;
      err_q     <= apb4_err_i;
    end
  end

  // Read data only on a good read
  always_ff @(posedge apb4_clk_i) begin
    if (bus_done && apb4_ack_i && !we_q) begin
      rdata_q <= aligned_rd;
    end
  end

  assign apb4_cyc_o = bus_active;
  assign apb4_stb_o = bus_active;
  assign apb4_adr_o = addr_q;
  assign apb4_dat_o = wdata_q;
  assign apb4_sel_o = sel_q;
  assign apb4_we_o  = we_q;

  // Held until the next completion, read after rdy_o rises
  assign data_o = rdata_q;
  assign err_o  = err_q;

endmodule

`default_nettype wire

// File: dbg_scratch_ram.sv
////////////////////////////////////////////////////////////
// Scratch RAM bus target with fixed wait states
// Word index at or above DBG_RAM_WORDS gets err, no write
// Contents are undefined after power-up
////////////////////////////////////////////////////////////

`default_nettype none

`include "dbg_bridge_config.svh"

module dbg_scratch_ram (
  input  logic        apb4_clk_i,
  input  logic        rst_i,
  input  logic [31:0] apb4_adr_i,
  input  logic [31:0] apb4_dat_i,
  input  logic [3:0]  apb4_sel_i,
  input  logic        apb4_we_i,
  input  logic        apb4_cyc_i,
  input  logic        apb4_stb_i,
  output logic [31:0] apb4_dat_o,
  output logic        apb4_ack_o,
  output logic        apb4_err_o
);

  localparam int RAM_WORDS = `DBG_RAM_WORDS;
  localparam int IDX_W     = $clog2(RAM_WORDS);
  localparam int WAIT      = `DBG_RAM_WAIT;

  logic [31:0]      mem [RAM_WORDS];
  logic [2:0]       wait_q;
  logic             pending;
  logic             answer;
  logic             in_range;
  logic [IDX_W-1:0] idx;

  // Request seen and not yet answered
  assign pending  = apb4_cyc_i && apb4_stb_i && !apb4_ack_o && !apb4_err_o;
  assign answer   = pending && (wait_q == 3'(WAIT));
  assign in_range = (apb4_adr_i[31:2] < 30'(RAM_WORDS));
  assign idx      = apb4_adr_i[IDX_W+1:2];

  // Wait counter and single-cycle answer
  always_ff @(posedge apb4_clk_i or posedge rst_i) begin
    if (rst_i) begin
      wait_q     <= 3'd0;
      apb4_ack_o <= 1'b0;
      apb4_err_o <= 1'b0;
    end else begin
      apb4_ack_o <= answer && in_range;
      apb4_err_o <= answer && !in_range;
      wait_q     <= (pending && !answer) ? wait_q + 3'd1 : 3'd0;
    end
  end

  // Byte-enable write, or read word out with the ack
  always_ff @(posedge apb4_clk_i) begin
    if (answer && in_range) begin
      if (apb4_we_i) begin
        for (int lane = 0; lane < 4; lane++) begin
          if (apb4_sel_i[lane]) begin
            mem[idx][lane*8 +: 8] <= apb4_dat_i[lane*8 +: 8];
          end
        end
      end else begin
        apb4_dat_o <= mem[idx];
      end
    end
  end

endmodule

`default_nettype wire

// File: dbg_bus_access_top.sv
////////////////////////////////////////////////////////////
// Debug bus access port with its scratch RAM target
// tck_i and apb4_clk_i are unrelated, rst_i resets both
////////////////////////////////////////////////////////////

`default_nettype none

module dbg_bus_access_top (
  input  logic        tck_i,
  input  logic        apb4_clk_i,
  input  logic        rst_i,
  input  logic        strobe_i,
  input  logic        rd_wrn_i,
  input  logic [2:0]  word_size_i,
  input  logic [31:0] addr_i,
  input  logic [31:0] data_i,
  output logic        rdy_o,
  output logic        err_o,
  output logic [31:0] data_o
);

  // Bus between bridge and RAM
  logic [31:0] apb4_adr;
  logic [31:0] apb4_dat_w;
  logic [31:0] apb4_dat_r;
  logic [3:0]  apb4_sel;
  logic        apb4_we;
  logic        apb4_cyc;
  logic        apb4_stb;
  logic        apb4_ack;
  logic        apb4_err;

  dbg_bus_bridge u_bridge (
    .tck_i       (tck_i),
    .rst_i       (rst_i),
    .strobe_i    (strobe_i),
    .rd_wrn_i    (rd_wrn_i),
    .word_size_i (dbg_bridge_pkg::access_size_e'(word_size_i)),
    .addr_i      (addr_i),
    .data_i      (data_i),
    .rdy_o       (rdy_o),
    .err_o       (err_o),
    .data_o      (data_o),
    .apb4_clk_i  (apb4_clk_i),
    .apb4_adr_o  (apb4_adr),
    .apb4_dat_o  (apb4_dat_w),
    .apb4_dat_i  (apb4_dat_r),
    .apb4_sel_o  (apb4_sel),
    .apb4_we_o   (apb4_we),
    .apb4_cyc_o  (apb4_cyc),
    .apb4_stb_o  (apb4_stb),
    .apb4_ack_i  (apb4_ack),
    .apb4_err_i  (apb4_err)
  );

  dbg_scratch_ram u_ram (
    .apb4_clk_i (apb4_clk_i),
    .rst_i      (rst_i),
    .apb4_adr_i (apb4_adr),
    .apb4_dat_i (apb4_dat_w),
    .apb4_sel_i (apb4_sel),
    .apb4_we_i  (apb4_we),
    .apb4_cyc_i (apb4_cyc),
    .apb4_stb_i (apb4_stb),
    .apb4_dat_o (apb4_dat_r),
    .apb4_ack_o (apb4_ack),
    .apb4_err_o (apb4_err)
  );

endmodule

`default_nettype wire

// File: tb_dbg_bus_access.sv
////////////////////////////////////////////////////////////
// Testbench for the debug bus access port
// RAM is filled first, so every in-range read has a known value
// Fixed seed, so every run repeats the same operations
////////////////////////////////////////////////////////////

`default_nettype none

`include "dbg_bridge_config.svh"

module tb_dbg_bus_access;

  localparam int RAM_WORDS  = `DBG_RAM_WORDS;
  localparam int RANDOM_OPS = 200;
  // Fill writes, directed operations, random operations
  localparam int NUM_OPS    = RAM_WORDS + 20 + RANDOM_OPS;
  localparam int TIMEOUT    = NUM_OPS * 40 + 16;

  logic        apb4_clk_i;
  logic        tck_i;
  logic        rst_i;
  logic        strobe_i;
  logic        rd_wrn_i;
  logic [2:0]  word_size_i;
  logic [31:0] addr_i;
  logic [31:0] data_i;
  logic        rdy_o;
  logic        err_o;
  logic [31:0] data_o;

  // Reference memory, lane 0 is the lowest address
  logic [31:0] ref_mem [RAM_WORDS];
  // Expected results in issue order, mask 0 skips the data check
  logic [31:0] exp_data_q [$];
  logic [31:0] exp_mask_q [$];
  logic        exp_err_q [$];

  integer seed      = 1358;
  int     checks    = 0;
  int     errors    = 0;
  int     cycle_cnt = 0;
  logic   rdy_prev  = 1'b1;

  dbg_bus_access_top u_dut (
    .tck_i       (tck_i),
    .apb4_clk_i  (apb4_clk_i),
    .rst_i       (rst_i),
    .strobe_i    (strobe_i),
    .rd_wrn_i    (rd_wrn_i),
    .word_size_i (word_size_i),
    .addr_i      (addr_i),
    .data_i      (data_i),
    .rdy_o       (rdy_o),
    .err_o       (err_o),
    .data_o      (data_o)
  );

  // Unrelated clocks, 100 and 140 time units
  always #50 apb4_clk_i = ~apb4_clk_i;
  always #70 tck_i = ~tck_i;

  // Returns {err, right-aligned read value}; a write updates ref_mem
  function automatic logic [32:0] ref_access(input logic rd, input logic [2:0] size,
                                             input logic [31:0] addr, input logic [31:0] data);
    int          nbytes;
    int          lane0;
    int          idx;
    logic [31:0] wval;
    logic [31:0] word;
    logic [31:0] value;
    nbytes = (size == 3'd1) ? 1 : (size == 3'd2) ? 2 : 4;
    lane0  = (nbytes == 1) ? int'(addr[1:0]) : (nbytes == 2) ? 2 * int'(addr[1]) : 0;
    idx    = int'(addr[31:2]);
    value  = 32'h0;
    if (idx < RAM_WORDS) begin
      word = ref_mem[idx];
      // Short write data sits in the top bytes of data
      wval = data >> (32 - 8 * nbytes);
      for (int k = 0; k < nbytes; k++) begin
        if (rd) begin
          value[k * 8 +: 8] = word[(lane0 + k) * 8 +: 8];
        end else begin
          word[(lane0 + k) * 8 +: 8] = wval[k * 8 +: 8];
        end
      end
      ref_mem[idx] = word;
    end
    return {(idx >= RAM_WORDS), value};
  endfunction

  // One request; hold > 0 keeps strobe high while busy, with other data
  task automatic run_op(input logic rd, input logic [2:0] size, input logic [31:0] addr,
                        input logic [31:0] data, input int hold);
    logic [32:0] expd;
    logic [31:0] mask;
    expd = ref_access(rd, size, addr, data);
    if (!rd || expd[32]) begin
      mask = 32'h0;
    end else if (size == 3'd1) begin
      mask = 32'h0000_00ff;
    end else if (size == 3'd2) begin
      mask = 32'h0000_ffff;
    end else begin
      mask = 32'hffff_ffff;
    end
    exp_data_q.push_back(expd[31:0]);
    exp_mask_q.push_back(mask);
    exp_err_q.push_back(expd[32]);
    @(posedge tck_i);
    while (!rdy_o) @(posedge tck_i);
    strobe_i    <= 1'b1;
    rd_wrn_i    <= rd;
    word_size_i <= size;
    addr_i      <= addr;
    data_i      <= data;
    // Accepted at this edge
    @(posedge tck_i);
    repeat (hold) begin
      data_i <= ~data;
      @(posedge tck_i);
    end
    strobe_i <= 1'b0;
    @(posedge tck_i);
    while (!rdy_o) @(posedge tck_i);
  endtask

  ////////////////////////////////////////////////////////////
  // Compare on each rise of rdy_o
  ////////////////////////////////////////////////////////////

  always @(posedge tck_i) begin
    logic [31:0] exp_data;
    logic [31:0] exp_mask;
    logic        exp_err;
    if (!rst_i) begin
      if (rdy_o && !rdy_prev) begin
        if (exp_err_q.size() == 0) begin
          $display("Error at %0t: a transfer completed that was never requested", $time);
          errors++;
        end else begin
          exp_data = exp_data_q.pop_front();
          exp_mask = exp_mask_q.pop_front();
          exp_err  = exp_err_q.pop_front();
          checks++;
          if (err_o !== exp_err) begin
            $display("FAILED at %0t: err_o %b, expected %b", $time, err_o, exp_err);
            errors++;
          end
          if (exp_mask != 32'h0) begin
            checks++;
            if ((data_o & exp_mask) !== (exp_data & exp_mask)) begin
              $display("FAILED at %0t: data_o %h, expected %h under mask %h",
                       $time, data_o, exp_data, exp_mask);
              errors++;
            end
          end
        end
      end
      rdy_prev = rdy_o;
    end
  end

  // Run limit in bus cycles
  always @(posedge apb4_clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT) begin
      $display("Timeout: the run did not end within %0d bus cycles (%0d errors so far)",
               TIMEOUT, errors);
      $display("Checks failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] rnd;
    logic [31:0] index;
    logic [31:0] addr;
    logic [31:0] data;
    logic [2:0]  size;
    apb4_clk_i  = 1'b0;
    tck_i       = 1'b0;
    rst_i       = 1'b1;
    strobe_i    = 1'b0;
    rd_wrn_i    = 1'b1;
    word_size_i = 3'd4;
    addr_i      = 32'h0;
    data_i      = 32'h0;
    repeat (16) @(posedge apb4_clk_i);
    rst_i <= 1'b0;
    @(posedge tck_i);
    // Idle state out of reset
    checks += 2;
    if (rdy_o !== 1'b1) begin
      $display("FAILED at %0t: rdy_o %b after reset, expected 1", $time, rdy_o);
      errors++;
    end
    if (err_o !== 1'b0) begin
      $display("FAILED at %0t: err_o %b after reset, expected 0", $time, err_o);
      errors++;
    end
    // Known contents everywhere, pattern from the whole word index
    for (int i = 0; i < RAM_WORDS; i++) begin
      run_op(1'b0, 3'd4, 32'(i) << 2, (32'(i) * 32'h9e37_79b9) ^ 32'h5a5a_0f0f, 0);
    end
    // Word write and read back
    run_op(1'b0, 3'd4, 32'h0000_0010, 32'hdead_beef, 0);
    run_op(1'b1, 3'd4, 32'h0000_0010, 32'h0, 0);
    // Byte lanes, low data bits must be ignored
    run_op(1'b0, 3'd1, 32'h0000_0020, 32'h11ab_cdef, 0);
    run_op(1'b0, 3'd1, 32'h0000_0021, 32'h2212_3456, 0);
    run_op(1'b0, 3'd1, 32'h0000_0022, 32'h33fe_dcba, 0);
    run_op(1'b0, 3'd1, 32'h0000_0023, 32'h4400_ff00, 0);
    run_op(1'b1, 3'd4, 32'h0000_0020, 32'h0, 0);
    // Halfwords in both halves, then short reads of each part
    run_op(1'b0, 3'd2, 32'h0000_0030, 32'ha1b2_9999, 0);
    run_op(1'b0, 3'd2, 32'h0000_0032, 32'hc3d4_7777, 0);
    run_op(1'b1, 3'd2, 32'h0000_0030, 32'h0, 0);
    run_op(1'b1, 3'd2, 32'h0000_0032, 32'h0, 0);
    for (int b = 0; b < 4; b++) begin
      run_op(1'b1, 3'd1, 32'h0000_0030 + 32'(b), 32'h0, 0);
    end
    // Word index RAM_WORDS aliases word 0 in the RAM array
    run_op(1'b0, 3'd4, 32'(RAM_WORDS) << 2, 32'hbad0_bad0, 0);
    run_op(1'b1, 3'd4, 32'(RAM_WORDS) << 2, 32'h0, 0);
    run_op(1'b1, 3'd4, 32'h0000_0000, 32'h0, 0);
    // Strobe held while busy, a second write would store ~data
    run_op(1'b0, 3'd4, 32'h0000_0040, 32'h1234_5678, 3);
    run_op(1'b1, 3'd4, 32'h0000_0040, 32'h0, 0);
    // Random mix, about one in eight out of range
    for (int n = 0; n < RANDOM_OPS; n++) begin
      rnd   = $unsigned($random(seed));
      index = $unsigned($random(seed)) % RAM_WORDS;
      if (rnd[5:3] == 3'd0) begin
        index = index + RAM_WORDS;
      end
      addr = (index << 2) | {30'b0, rnd[7:6]};
      data = $random(seed);
      size = (rnd[1:0] == 2'd0) ? 3'd1 : (rnd[1:0] == 2'd1) ? 3'd2 : 3'd4;
      run_op(rnd[2], size, addr, data, 0);
    end
    repeat (4) @(posedge tck_i);
    if (exp_err_q.size() != 0) begin
      $display("Error: %0d requests never completed", exp_err_q.size());
      errors++;
    end
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+.
dbg_bridge_pkg.sv
dbg_lane_steer.sv
dbg_toggle_sync.sv
dbg_bus_bridge.sv
dbg_scratch_ram.sv
dbg_bus_access_top.sv
tb_dbg_bus_access.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the debug bus access testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_dbg_bus_access -f src.f -o tb_sim \
  > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1 ; cat sim.log

grep -q "Checks failed" sim.log && { echo "Simulation reported failures"; exit 1; }
grep -q "All checks passed" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0
